//--- include/bp_consts.svh
// Branch predictor constants for address width, BTB size, history length and counter init

`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address and BTB geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BP_ADDR_W       32                      // Instruction address width
`define BP_BTB_ENTRIES  16                      // Power of two
`define BP_BTB_IDX_W    $clog2(`BP_BTB_ENTRIES)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direction predictor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// PHT holds 2**BP_GHR_W counters
`define BP_GHR_W        5

`define BP_CTR_INIT     2'b01                   // Weakly not taken

`endif

//--- verilog/bp_pkg.sv
// Branch predictor types for addresses, table indices, counters and fetch/execute records

`include "bp_consts.svh"

package bp_pkg;

    typedef logic [`BP_ADDR_W-1:0] addr_t;

    // Index sits just above the two byte-offset bits, tag takes the rest
    typedef logic [`BP_BTB_IDX_W-1:0]              btb_idx_t;
    typedef logic [`BP_ADDR_W-`BP_BTB_IDX_W-3:0]   btb_tag_t;

    typedef logic [`BP_GHR_W-1:0] ghr_t;    // Also the PHT index
    typedef logic [1:0]           ctr_t;

    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JUMP   = 2'd2
    } cf_kind_e;

    // Fetch side result
    typedef struct packed {
        logic     hit;
        logic     taken;
        addr_t    target;
        ghr_t     pht_idx;
    } bp_pred_t;

    // Execute side feedback
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        addr_t    target;
        cf_kind_e kind;
        logic     taken;
        ghr_t     pht_idx;  // Index used at fetch time
    } bp_resolve_t;

endpackage

//--- verilog/bp_btb.sv
// Direct-mapped branch target buffer storing tag, target and control-flow kind per entry

`include "bp_consts.svh"

module bp_btb (
    input  logic                clk,
    input  logic                rst_n_i,
    input  bp_pkg::addr_t       lookup_pc_i,
    output logic                lookup_hit_o,
    output bp_pkg::cf_kind_e    lookup_kind_o,
    output bp_pkg::addr_t       lookup_target_o,
    input  bp_pkg::bp_resolve_t resolve_i
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PC split helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic bp_pkg::btb_idx_t pc_index(input bp_pkg::addr_t pc);
        return pc[`BP_BTB_IDX_W+1:2];
    endfunction

    function automatic bp_pkg::btb_tag_t pc_tag(input bp_pkg::addr_t pc);
        return pc[`BP_ADDR_W-1:`BP_BTB_IDX_W+2];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    bp_pkg::btb_tag_t tag_mem    [0:`BP_BTB_ENTRIES-1];
    bp_pkg::addr_t    target_mem [0:`BP_BTB_ENTRIES-1];
    bp_pkg::cf_kind_e kind_mem   [0:`BP_BTB_ENTRIES-1];

    logic [`BP_BTB_ENTRIES-1:0] valid_q;

    bp_pkg::btb_idx_t lookup_idx;
    bp_pkg::btb_tag_t lookup_tag;
    bp_pkg::btb_idx_t wr_idx;
    bp_pkg::btb_tag_t wr_tag;
    logic             wr_en;

    assign lookup_idx = pc_index(lookup_pc_i);
    assign lookup_tag = pc_tag(lookup_pc_i);

    assign wr_idx = pc_index(resolve_i.pc);
    assign wr_tag = pc_tag(resolve_i.pc);
    assign wr_en  = resolve_i.valid && (resolve_i.kind != bp_pkg::CF_NONE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign lookup_hit_o    = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign lookup_kind_o   = kind_mem[lookup_idx];     // Top level qualifies with hit
    assign lookup_target_o = target_mem[lookup_idx];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Old entry at the same index is simply overwritten
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= resolve_i.target;
            kind_mem[wr_idx]   <= resolve_i.kind;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

endmodule

//--- verilog/bp_gshare.sv
// Gshare direction predictor with global history and 2-bit saturating counters

`include "bp_consts.svh"

module bp_gshare (
    input  logic                clk,
    input  logic                rst_n_i,
    input  bp_pkg::addr_t       lookup_pc_i,
    output bp_pkg::ghr_t        pht_idx_o,
    output logic                pred_taken_o,
    input  bp_pkg::bp_resolve_t resolve_i,
    input  logic                ghr_clear_i
);

    localparam int unsigned PHT_ENTRIES = 1 << `BP_GHR_W;

    bp_pkg::ghr_t ghr_q;
    bp_pkg::ctr_t pht_q [0:PHT_ENTRIES-1];

    bp_pkg::ctr_t ctr_cur;
    bp_pkg::ctr_t ctr_nxt;
    logic         branch_upd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pht_idx_o    = lookup_pc_i[`BP_GHR_W+1:2] ^ ghr_q;
    assign pred_taken_o = pht_q[pht_idx_o][1];  // Counter MSB

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Jumps leave counters and history alone
    assign branch_upd = resolve_i.valid && (resolve_i.kind == bp_pkg::CF_BRANCH);

    always_comb begin
        ctr_cur = pht_q[resolve_i.pht_idx];
        ctr_nxt = ctr_cur;
        if (resolve_i.taken) begin
            if (ctr_cur != 2'b11) begin
                ctr_nxt = ctr_cur + 2'b01;
            end
        end else if (ctr_cur != 2'b00) begin
            ctr_nxt = ctr_cur - 2'b01;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= `BP_CTR_INIT;
            end
        end else if (branch_upd) begin
            pht_q[resolve_i.pht_idx] <= ctr_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (ghr_clear_i) begin
            ghr_q <= '0;                                       // Wins over a shift
        end else if (branch_upd) begin
            ghr_q <= {ghr_q[`BP_GHR_W-2:0], resolve_i.taken};  // Newest outcome in LSB
        end
    end

endmodule

//--- verilog/bp_unit.sv
// Branch prediction unit combining BTB target lookup with gshare direction

module bp_unit (
    input  logic                clk,
    input  logic                rst_n_i,
    input  bp_pkg::addr_t       fetch_pc_i,
    output bp_pkg::bp_pred_t    pred_o,
    input  bp_pkg::bp_resolve_t resolve_i,
    input  logic                ghr_clear_i
);

    logic             btb_hit;
    bp_pkg::cf_kind_e btb_kind;
    bp_pkg::addr_t    btb_target;

    logic             dir_taken;
    bp_pkg::ghr_t     pht_idx;

    logic             is_jump;
    logic             is_branch;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    bp_btb btb_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .lookup_pc_i     (fetch_pc_i),
        .lookup_hit_o    (btb_hit),
        .lookup_kind_o   (btb_kind),
        .lookup_target_o (btb_target),
        .resolve_i       (resolve_i)
    );

    bp_gshare gshare_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .lookup_pc_i  (fetch_pc_i),
        .pht_idx_o    (pht_idx),
        .pred_taken_o (dir_taken),
        .resolve_i    (resolve_i),
        .ghr_clear_i  (ghr_clear_i)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prediction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign is_jump   = (btb_kind == bp_pkg::CF_JUMP);
    assign is_branch = (btb_kind == bp_pkg::CF_BRANCH);

    always_comb begin
        pred_o.hit     = btb_hit;
        // Jumps always redirect, branches follow the counter
        pred_o.taken   = btb_hit && (is_jump || (is_branch && dir_taken));
        pred_o.target  = btb_hit ? btb_target : '0;
        pred_o.pht_idx = pht_idx;   // Carried to execute for the update
    end

endmodule

//--- bench/bp_properties.sv
// Output assertions for the branch prediction unit, bound into bp_unit

module bp_properties (
    input logic             clk,
    input logic             rst_n_i,
    input bp_pkg::bp_pred_t pred_i
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prediction consistency
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    taken_needs_hit: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pred_i.taken |-> pred_i.hit
    ) else $error("Taken prediction without a BTB hit");

    // Target is forced to zero on a miss
    miss_zero_target: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !pred_i.hit |-> (pred_i.target == '0)
    ) else $error("BTB miss with a nonzero target");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    no_hit_after_reset: assert property (
        @(posedge clk)
        $rose(rst_n_i) |-> !pred_i.hit
    ) else $error("BTB hit in the first cycle after reset release");

endmodule

bind bp_unit bp_properties props_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .pred_i  (pred_o)
);

//--- bench/bp_tb.sv
// Testbench for the branch prediction unit, replaying lookup and resolve records from a file

`include "bp_consts.svh"

module bp_tb;

    localparam int MAX_RECORDS = 64;
    localparam int REC_WORDS   = 6;    // type, pc, target, a, b, idx

    localparam logic [31:0] REC_END     = 32'h0;
    localparam logic [31:0] REC_RESOLVE = 32'h1;
    localparam logic [31:0] REC_LOOKUP  = 32'h2;
    localparam logic [31:0] REC_CLEAR   = 32'h3;

    logic                clk;
    logic                rst_n;
    bp_pkg::addr_t       fetch_pc;
    bp_pkg::bp_pred_t    pred;
    bp_pkg::bp_resolve_t resolve;
    logic                ghr_clear;

    logic [31:0] test_mem [0:MAX_RECORDS*REC_WORDS-1];

    int num_records = 0;
    int cycle_limit = 1000000;
    int cycle_count = 0;

    bp_unit dut_i (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .fetch_pc_i  (fetch_pc),
        .pred_o      (pred),
        .resolve_i   (resolve),
        .ghr_clear_i (ghr_clear)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_on_error($sformatf("Timeout after %0d cycles, records did not finish",
                                    cycle_count));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Records end at the first zero type word
    function automatic int count_records();
        int n;
        n = 0;
        while (n < MAX_RECORDS && test_mem[n*REC_WORDS] != REC_END) begin
            n++;
        end
        return n;
    endfunction

    task automatic run_record(input int rec);
        logic [31:0]         rec_type;
        logic [31:0]         pc_w;
        logic [31:0]         tgt_w;
        logic [31:0]         f_a;
        logic [31:0]         f_b;
        logic [31:0]         f_idx;
        bp_pkg::bp_resolve_t res;
        logic                clr;
        rec_type = test_mem[rec*REC_WORDS];
        pc_w     = test_mem[rec*REC_WORDS+1];
        tgt_w    = test_mem[rec*REC_WORDS+2];
        f_a      = test_mem[rec*REC_WORDS+3];
        f_b      = test_mem[rec*REC_WORDS+4];
        f_idx    = test_mem[rec*REC_WORDS+5];
        res      = '0;
        clr      = 1'b0;
        case (rec_type)
            REC_RESOLVE: begin
                res.valid   = 1'b1;
                res.pc      = pc_w;
                res.target  = tgt_w;
                res.kind    = bp_pkg::cf_kind_e'(f_a[1:0]);
                res.taken   = f_b[0];
                res.pht_idx = f_idx[`BP_GHR_W-1:0];
            end
            REC_LOOKUP: begin
                res = '0;
            end
            REC_CLEAR: begin
                clr = 1'b1;
            end
            default: begin
                stop_on_error($sformatf("Unknown record type %0h in record %0d", rec_type, rec));
            end
        endcase
        @(posedge clk);
        resolve   <= res;          // Valid for exactly one cycle
        ghr_clear <= clr;
        if (rec_type == REC_LOOKUP) begin
            fetch_pc <= pc_w;
            @(negedge clk);        // Prediction settled mid cycle
            check_value("pred_o.hit", 32'(pred.hit), f_a);
            check_value("pred_o.taken", 32'(pred.taken), f_b);
            check_value("pred_o.target", pred.target, tgt_w);
            check_value("pred_o.pht_idx", 32'(pred.pht_idx), f_idx);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n     <= 1'b0;
        fetch_pc  <= '0;
        resolve   <= '0;
        ghr_clear <= 1'b0;
        for (int i = 0; i < MAX_RECORDS*REC_WORDS; i++) begin
            test_mem[i] = '0;
        end
        $readmemh("bench/bp_tests.txt", test_mem);
        num_records = count_records();
        if (num_records == 0) begin
            stop_on_error("No test records found in bench/bp_tests.txt");
        end
        cycle_limit = 4 * num_records + 50;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int r = 0; r < num_records; r++) begin
            run_record(r);
        end

        // Let a trailing resolve land
        @(posedge clk);
        resolve   <= '0;
        ghr_clear <= 1'b0;
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- bench/bp_tests.txt
// Branch predictor records, six hex words per line: type pc target a b idx
// type 1 resolve (a kind 0/1/2 none/branch/jump, b taken, idx carried PHT index)
// type 2 lookup (a hit, b taken, target and idx expected), type 3 history clear

// Cold table, every PC misses and idx is PC[6:2]
2 00000100 00000000 0 0 00
2 0000102C 00000000 0 0 0B
2 8000007C 00000000 0 0 1F

// Jump at 0x200, history untouched
1 00000200 00000480 2 1 00
2 00000200 00000480 1 1 00

// Kind none writes nothing, same BTB slot as 0x200
1 00000300 00000900 0 1 00
2 00000300 00000000 0 0 00
2 00000200 00000480 1 1 00

// Branch at 0x344 trains counter 11
1 00000344 00000500 1 1 11
2 00000344 00000500 1 0 10    // ghr 00001
3 00000000 00000000 0 0 00
2 00000344 00000500 1 1 11    // Weakly taken now
1 00000344 00000500 1 0 11
2 00000344 00000500 1 0 11
1 00000344 00000500 1 0 11
1 00000344 00000500 1 0 11    // Stays at 0
2 00000344 00000500 1 0 11
1 00000344 00000500 1 1 11
1 00000344 00000500 1 1 11    // ctr 2, ghr 00011
2 00000344 00000500 1 0 12
3 00000000 00000000 0 0 00
2 00000344 00000500 1 1 11

// Saturate at 3, then two steps down
1 00000344 00000500 1 1 11
1 00000344 00000500 1 1 11
1 00000344 00000500 1 0 11
1 00000344 00000500 1 0 11    // ctr 1, ghr 01100
2 0000102C 00000000 0 0 07
2 00000344 00000500 1 0 1D
3 00000000 00000000 0 0 00
2 00000344 00000500 1 0 11
2 0000102C 00000000 0 0 0B

// Same BTB index, different tags
1 00000208 00000600 2 1 02
2 00000208 00000600 1 1 02
1 00001208 00000700 2 1 02
2 00001208 00000700 1 1 02
2 00000208 00000000 0 0 02    // Evicted
2 00000200 00000480 1 1 00

// Slot reused by a not-taken branch
1 00001208 00000740 1 0 02
2 00001208 00000740 1 0 02

//--- filelist.f
+incdir+include
verilog/bp_pkg.sv
verilog/bp_btb.sv
verilog/bp_gshare.sv
verilog/bp_unit.sv
bench/bp_properties.sv
bench/bp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the branch predictor testbench with Verilator and run it

set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    --top-module bp_tb \
    -Mdir "$BUILD_DIR" \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vbp_tb"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

echo "Simulation exited cleanly"
exit 0
